//--- icacheTop.f
hdl/cachePkg.sv
hdl/axiLitePkg.sv
hdl/cacheWay.sv
hdl/waySelect.sv
hdl/cacheCtrl.sv
hdl/icacheTop.sv
tb/axiLiteMemModel.sv
tb/icacheTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= icacheTb
FILELIST  ?= icacheTop.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi
	@grep -q '\*\* PASS \*\*' $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/icacheTb.sv
module icacheTb;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_WAYS = 2;
  localparam int NUM_SETS = 64;
  localparam int OFFSET_BITS = 5;
  localparam int TAG_SHIFT = OFFSET_BITS + $clog2(NUM_SETS);
  localparam int NUM_ENTRIES = 27;
  localparam int LIMIT_CYCLES = NUM_ENTRIES * 64;

  localparam logic [2:0] MISS_READS = 3'd4;
  localparam logic [2:0] HIT_READS = 3'd0;
  // instruction access, secure, unprivileged
  localparam logic [2:0] FETCH_PROT = 3'b100;
  // serial waits for the word before the next request, stream does not
  localparam logic SERIAL = 1'b1;
  localparam logic STREAM = 1'b0;

  typedef struct packed {
    logic           doReset;
    logic           waitData;
    cachePkg::addrT addr;
    logic [2:0]     expAr;
    cachePkg::wordT expWord;
  } entryT;

  typedef struct packed {
    int         idx;
    int         acceptCycle;
    int         arSnap;
    logic [2:0] refAr;
  } respT;

  logic                 clk;
  logic                 rst_n;
  logic                 valid;
  cachePkg::addrT       addr;
  logic                 addrOk;
  logic                 dataOk;
  cachePkg::wordT       rdData;
  axiLitePkg::axiArT    axiAr;
  logic                 arready;
  axiLitePkg::axiRT     axiR;
  logic                 rready;
  axiLitePkg::axiAwT    axiAw;
  axiLitePkg::axiWT     axiW;
  axiLitePkg::axiBT     axiB;
  logic                 bready;

  entryT tbl [NUM_ENTRIES];
  int    presentQ [$];
  respT  respQ [$];

  // reference cache state
  logic        refValid [NUM_SETS][NUM_WAYS];
  logic [31:0] refTag [NUM_SETS][NUM_WAYS];
  int          refPtr [NUM_SETS];

  int             cycle;
  int             arTotal;
  int             doneCount;
  int             issued;
  int             drvDone;
  int             lastAccept;
  logic           prevHitStream;
  cachePkg::addrT missBase;
  int             missBeats;

  icacheTop #(
    .NUM_WAYS(NUM_WAYS),
    .NUM_SETS(NUM_SETS)
  ) dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_i   (valid),
    .addr_i    (addr),
    .addrOk_o  (addrOk),
    .dataOk_o  (dataOk),
    .rdData_o  (rdData),
    .axiAr_o   (axiAr),
    .arready_i (arready),
    .axiR_i    (axiR),
    .rready_o  (rready),
    .axiAw_o   (axiAw),
    .axiW_o    (axiW),
    .axiB_i    (axiB),
    .bready_o  (bready)
  );

  axiLiteMemModel mem0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .axiAr_i   (axiAr),
    .arready_o (arready),
    .axiR_o    (axiR),
    .rready_i  (rready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic checkEq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic abortRun(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("** FAIL **");
    $fatal(1, "run aborted");
  endtask

  // memory word seen by a fetch of any byte in its 8-byte slot
  function automatic cachePkg::wordT expectedWord(input cachePkg::addrT a);
    cachePkg::addrT base;
    base = a & ~32'h7;
    return {base, ~base};
  endfunction

  function automatic entryT makeEntry(input cachePkg::addrT a, input logic [2:0] arReads,
                                      input logic waitForData);
    entryT e;
    e.doReset = 1'b0;
    e.waitData = waitForData;
    e.addr = a;
    e.expAr = arReads;
    e.expWord = expectedWord(a);
    return e;
  endfunction

  function automatic entryT resetEntry();
    entryT e;
    e = '0;
    e.doReset = 1'b1;
    return e;
  endfunction

  function automatic void forgetLines();
    for (int s = 0; s < NUM_SETS; s++) begin
      refPtr[s] = 0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        refValid[s][w] = 1'b0;
        refTag[s][w] = '0;
      end
    end
  endfunction

  // returns the AR reads the access should cost, and fills on a miss
  function automatic logic [2:0] predictAccess(input cachePkg::addrT a);
    int          setIdx;
    logic [31:0] tag;
    setIdx = int'((a >> OFFSET_BITS) % 32'(NUM_SETS));
    tag = a >> TAG_SHIFT;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (refValid[setIdx][w] && refTag[setIdx][w] == tag) begin
        return HIT_READS;
      end
    end
    refValid[setIdx][refPtr[setIdx]] = 1'b1;
    refTag[setIdx][refPtr[setIdx]] = tag;
    refPtr[setIdx] = (refPtr[setIdx] + 1) % NUM_WAYS;
    return MISS_READS;
  endfunction

  task automatic fillTable();
    // first touch of four lines, one word each
    tbl[0] = makeEntry(32'h0000_0040, MISS_READS, SERIAL);
    tbl[1] = makeEntry(32'h0000_0068, MISS_READS, SERIAL);
    tbl[2] = makeEntry(32'h0000_0090, MISS_READS, SERIAL);
    tbl[3] = makeEntry(32'h0000_00b8, MISS_READS, SERIAL);
    // streamed hits over the filled lines
    tbl[4] = makeEntry(32'h0000_0040, HIT_READS, STREAM);
    tbl[5] = makeEntry(32'h0000_0048, HIT_READS, STREAM);
    tbl[6] = makeEntry(32'h0000_0050, HIT_READS, STREAM);
    tbl[7] = makeEntry(32'h0000_0058, HIT_READS, STREAM);
    tbl[8] = makeEntry(32'h0000_0060, HIT_READS, STREAM);
    tbl[9] = makeEntry(32'h0000_0078, HIT_READS, STREAM);
    tbl[10] = makeEntry(32'h0000_0098, HIT_READS, STREAM);
    tbl[11] = makeEntry(32'h0000_00a0, HIT_READS, SERIAL);
    // three tags in set 0, round-robin eviction
    tbl[12] = makeEntry(32'h0000_1000, MISS_READS, SERIAL);
    tbl[13] = makeEntry(32'h0000_1808, MISS_READS, SERIAL);
    tbl[14] = makeEntry(32'h0000_2010, MISS_READS, SERIAL);
    tbl[15] = makeEntry(32'h0000_1818, HIT_READS, SERIAL);
    tbl[16] = makeEntry(32'h0000_1000, MISS_READS, SERIAL);
    tbl[17] = makeEntry(32'h0000_2018, HIT_READS, SERIAL);
    tbl[18] = makeEntry(32'h0000_1800, MISS_READS, SERIAL);
    // reset drops every line
    tbl[19] = resetEntry();
    tbl[20] = makeEntry(32'h0000_0040, MISS_READS, SERIAL);
    tbl[21] = makeEntry(32'h0000_1000, MISS_READS, SERIAL);
    tbl[22] = makeEntry(32'h0000_1008, HIT_READS, SERIAL);
    // set 63, request held waiting behind a refill
    tbl[23] = makeEntry(32'h0001_f7e0, MISS_READS, SERIAL);
    tbl[24] = makeEntry(32'hffff_fff8, MISS_READS, STREAM);
    tbl[25] = makeEntry(32'h0001_f7e8, HIT_READS, STREAM);
    tbl[26] = makeEntry(32'hffff_ffe0, HIT_READS, SERIAL);
  endtask

  // driver side count of returned words
  task automatic stepClock();
    @(posedge clk);
    if (dataOk) begin
      drvDone++;
    end
  endtask

  task automatic drainResponses();
    while (drvDone < issued) begin
      stepClock();
    end
  endtask

  task automatic applyReset();
    rst_n <= 1'b0;
    repeat (8) stepClock();
    rst_n <= 1'b1;
  endtask

  always @(posedge clk) begin : observe
    respT  r;
    entryT e;
    int    gotAr;
    cycle = cycle + 1;
    if (!rst_n) begin
      forgetLines();
      prevHitStream = 1'b0;
    end else begin
      // write side of the bus stays quiet for a read-only cache
      checkEq(64'({|axiAw, |axiW, bready}), 64'(0), "write channels idle");
      if (axiAr.arvalid && arready) begin
        checkEq(64'(axiAr.araddr), 64'(missBase + 32'(8 * missBeats)), "AR address");
        checkEq(64'(axiAr.arprot), 64'(FETCH_PROT), "AR protection");
        missBeats = missBeats + 1;
        arTotal = arTotal + 1;
      end
      // no new request while the line is being fetched
      if (axiAr.arvalid || rready) begin
        checkEq(64'(addrOk), 64'(0), "addrOk_o during refill");
      end
      if (dataOk) begin
        if (respQ.size() == 0) begin
          abortRun("dataOk_o pulsed with no request outstanding");
        end else begin
          r = respQ.pop_front();
          e = tbl[r.idx];
          checkEq(rdData, e.expWord, "read data");
          gotAr = arTotal - r.arSnap;
          checkEq(64'(gotAr), 64'(r.refAr), "AR reads for request");
          if (r.refAr == HIT_READS) begin
            checkEq(64'(cycle - r.acceptCycle), 64'(2), "hit latency");
          end
          doneCount = doneCount + 1;
        end
      end
      if (valid && addrOk) begin
        if (presentQ.size() == 0) begin
          abortRun("request accepted that was never presented");
        end else begin
          r.idx = presentQ.pop_front();
          e = tbl[r.idx];
          r.refAr = predictAccess(e.addr);
          checkEq(64'(r.refAr), 64'(e.expAr), "model AR reads against table");
          if (prevHitStream) begin
            checkEq(64'(cycle - lastAccept), 64'(1), "back-to-back accept spacing");
          end
          prevHitStream = (r.refAr == HIT_READS) && !e.waitData;
          lastAccept = cycle;
          r.acceptCycle = cycle;
          r.arSnap = arTotal;
          if (r.refAr != HIT_READS) begin
            missBase = e.addr & ~32'h1f;
            missBeats = 0;
          end
          respQ.push_back(r);
        end
      end
    end
  end

  initial begin : watchdog
    #(LIMIT_CYCLES * CLK_PERIOD);
    abortRun($sformatf("timeout, run did not finish within %0d cycles", LIMIT_CYCLES));
  end

  initial begin : drive
    clk = 1'b0;
    rst_n = 1'b0;
    valid = 1'b0;
    addr = '0;
    axiB = '0;
    issued = 0;
    drvDone = 0;
    fillTable();
    applyReset();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (tbl[i].doReset) begin
        valid <= 1'b0;
        drainResponses();
        applyReset();
      end else begin
        presentQ.push_back(i);
        valid <= 1'b1;
        addr <= tbl[i].addr;
        issued++;
        stepClock();
        while (!addrOk) begin
          stepClock();
        end
        if (tbl[i].waitData) begin
          valid <= 1'b0;
          drainResponses();
        end
      end
    end
    valid <= 1'b0;
    drainResponses();
    repeat (4) stepClock();
    if (doneCount == issued && respQ.size() == 0 && presentQ.size() == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      abortRun("not every request received exactly one word");
    end
  end

endmodule

//--- tb/axiLiteMemModel.sv
module axiLiteMemModel (
  input  logic              clk,
  input  logic              rst_n,
  input  axiLitePkg::axiArT axiAr_i,
  output logic              arready_o,
  output axiLitePkg::axiRT  axiR_o,
  input  logic              rready_i
);

  integer seed = 32'hcdb0175f;

  logic [1:0]          arDelay;
  logic [1:0]          rDelay;
  logic                pending;
  axiLitePkg::axiAddrT pendAddr;

  // memory contents, address in the upper half and its inverse below
  function automatic axiLitePkg::axiDataT patternAt(input axiLitePkg::axiAddrT a);
    return {a, ~a};
  endfunction

  initial begin
    arready_o = 1'b0;
    axiR_o = '0;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arready_o <= 1'b0;
      axiR_o <= '0;
      arDelay <= '0;
      rDelay <= '0;
      pending <= 1'b0;
      pendAddr <= '0;
    end else begin
      // address channel, one read in flight at most
      if (axiAr_i.arvalid && arready_o) begin
        arready_o <= 1'b0;
        pending <= 1'b1;
        pendAddr <= axiAr_i.araddr;
        rDelay <= 2'($random(seed));
        arDelay <= 2'($random(seed));
      end else if (axiAr_i.arvalid && !pending) begin
        if (arDelay == 2'd0) begin
          arready_o <= 1'b1;
        end else begin
          arDelay <= arDelay - 2'd1;
        end
      end
      // data channel
      if (axiR_o.rvalid && rready_i) begin
        axiR_o.rvalid <= 1'b0;
        pending <= 1'b0;
      end else if (pending && !axiR_o.rvalid) begin
        if (rDelay == 2'd0) begin
          axiR_o.rvalid <= 1'b1;
          axiR_o.rdata <= patternAt(pendAddr);
          axiR_o.rresp <= axiLitePkg::RESP_OKAY;
        end else begin
          rDelay <= rDelay - 2'd1;
        end
      end
    end
  end

endmodule

//--- hdl/icacheTop.sv
module icacheTop #(
  parameter int NUM_WAYS = 2,
  parameter int NUM_SETS = 64,
  localparam int INDEX_BITS = $clog2(NUM_SETS),
  localparam int TAG_BITS = $bits(cachePkg::addrT) - INDEX_BITS - cachePkg::OFFSET_BITS
) (
  input  logic               clk,
  input  logic               rst_n,
  // fetch pipeline
  input  logic               valid_i,
  input  cachePkg::addrT     addr_i,
  output logic               addrOk_o,
  output logic               dataOk_o,
  output cachePkg::wordT     rdData_o,
  // memory read channels
  output axiLitePkg::axiArT  axiAr_o,
  input  logic               arready_i,
  input  axiLitePkg::axiRT   axiR_i,
  output logic               rready_o,
  // memory write channels, never used
  output axiLitePkg::axiAwT  axiAw_o,
  output axiLitePkg::axiWT   axiW_o,
  input  axiLitePkg::axiBT   axiB_i,
  output logic               bready_o
);

  logic                          lookupEn;
  cachePkg::addrT                lookupAddr;
  logic [NUM_WAYS-1:0]           fillEn;
  logic [INDEX_BITS-1:0]         fillIndex;
  logic [TAG_BITS-1:0]           fillTag;
  cachePkg::lineT                fillLine;
  logic [NUM_WAYS-1:0]           hit;
  cachePkg::lineT [NUM_WAYS-1:0] wayLine;
  logic                          refillSel;
  logic                          selLoad;
  logic [1:0]                    wordOffset;

  cacheCtrl #(
    .NUM_WAYS(NUM_WAYS),
    .NUM_SETS(NUM_SETS)
  ) ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid_i),
    .addr_i       (addr_i),
    .addrOk_o     (addrOk_o),
    .hit_i        (hit),
    .lookupEn_o   (lookupEn),
    .lookupAddr_o (lookupAddr),
    .fillEn_o     (fillEn),
    .fillIndex_o  (fillIndex),
    .fillTag_o    (fillTag),
    .fillLine_o   (fillLine),
    .refillSel_o  (refillSel),
    .selLoad_o    (selLoad),
    .wordOffset_o (wordOffset),
    .axiAr_o      (axiAr_o),
    .arready_i    (arready_i),
    .axiR_i       (axiR_i),
    .rready_o     (rready_o)
  );

  for (genvar w = 0; w < NUM_WAYS; w++) begin : genWay
    cacheWay #(
      .NUM_SETS(NUM_SETS)
    ) way (
      .clk          (clk),
      .rst_n        (rst_n),
      .lookupEn_i   (lookupEn),
      .lookupAddr_i (lookupAddr),
      .fillEn_i     (fillEn[w]),
      .fillIndex_i  (fillIndex),
      .fillTag_i    (fillTag),
      .fillLine_i   (fillLine),
      .hit_o        (hit[w]),
      .line_o       (wayLine[w])
    );
  end

  waySelect #(
    .NUM_WAYS(NUM_WAYS)
  ) sel (
    .clk          (clk),
    .rst_n        (rst_n),
    .hit_i        (hit),
    .wayLine_i    (wayLine),
    .refillLine_i (fillLine),
    .refillSel_i  (refillSel),
    .selLoad_i    (selLoad),
    .wordOffset_i (wordOffset),
    .rdData_o     (rdData_o),
    .dataOk_o     (dataOk_o)
  );

  // read-only cache, write side stays idle
  assign axiAw_o = '0;
  assign axiW_o = '0;
  assign bready_o = 1'b0;

  // no write is ever issued, so no response may come back
  noWriteResp: assert property (
    @(posedge clk) disable iff (!rst_n)
    !axiB_i.bvalid
  );

endmodule

//--- hdl/cacheCtrl.sv
module cacheCtrl #(
  parameter int NUM_WAYS = 2,
  parameter int NUM_SETS = 64,
  localparam int INDEX_BITS = $clog2(NUM_SETS),
  localparam int TAG_BITS = $bits(cachePkg::addrT) - INDEX_BITS - cachePkg::OFFSET_BITS
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  valid_i,
  input  cachePkg::addrT        addr_i,
  output logic                  addrOk_o,
  input  logic [NUM_WAYS-1:0]   hit_i,
  output logic                  lookupEn_o,
  output cachePkg::addrT        lookupAddr_o,
  output logic [NUM_WAYS-1:0]   fillEn_o,
  output logic [INDEX_BITS-1:0] fillIndex_o,
  output logic [TAG_BITS-1:0]   fillTag_o,
  output cachePkg::lineT        fillLine_o,
  output logic                  refillSel_o,
  output logic                  selLoad_o,
  output logic [1:0]            wordOffset_o,
  output axiLitePkg::axiArT     axiAr_o,
  input  logic                  arready_i,
  input  axiLitePkg::axiRT      axiR_i,
  output logic                  rready_o
);

  localparam int WAY_BITS = $clog2(NUM_WAYS);

  cachePkg::ctrlStateT state;
  cachePkg::ctrlStateT nextState;

  cachePkg::addrT               reqAddr;
  cachePkg::lineT               lineReg;
  logic [1:0]                   beat;
  logic [NUM_SETS-1:0][WAY_BITS-1:0] rrPtr;
  logic [INDEX_BITS-1:0]        reqIndex;
  logic [WAY_BITS-1:0]          victim;
  logic [WAY_BITS-1:0]          nextPtr;
  logic                         anyHit;
  logic                         accept;
  logic                         beatTaken;
  logic                         lastBeat;

  assign anyHit = |hit_i;
  assign reqIndex = reqAddr[cachePkg::OFFSET_BITS +: INDEX_BITS];
  assign victim = rrPtr[reqIndex];
  assign nextPtr = (victim == WAY_BITS'(NUM_WAYS - 1)) ? '0 : victim + 1'b1;

  // a new request can go in while idle or right behind a hit
  assign addrOk_o = (state == cachePkg::IDLE) || (state == cachePkg::COMPARE && anyHit);
  assign accept = valid_i && addrOk_o;

  // arrays are read on the accepting edge
  assign lookupEn_o = accept;
  assign lookupAddr_o = addr_i;

  assign beatTaken = rready_o && axiR_i.rvalid;
  assign lastBeat = (beat == 2'(cachePkg::WORDS_PER_LINE - 1));

  always_comb begin
    nextState = state;
    case (state)
      cachePkg::IDLE: begin
        if (valid_i) begin
          nextState = cachePkg::COMPARE;
        end
      end
      cachePkg::COMPARE: begin
        if (!anyHit) begin
          nextState = cachePkg::REFILL_ADDR;
        end else if (!valid_i) begin
          nextState = cachePkg::IDLE;
        end
      end
      cachePkg::REFILL_ADDR: begin
        if (arready_i) begin
          nextState = cachePkg::REFILL_DATA;
        end
      end
      cachePkg::REFILL_DATA: begin
        if (axiR_i.rvalid) begin
          nextState = lastBeat ? cachePkg::RESPOND : cachePkg::REFILL_ADDR;
        end
      end
      default: begin
        nextState = cachePkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cachePkg::IDLE;
      beat <= '0;
    end else begin
      state <= nextState;
      // wraps back to zero after the last beat
      if (beatTaken) begin
        beat <= beat + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= addr_i;
    end
    if (beatTaken) begin
      lineReg[beat * cachePkg::WORD_BITS +: cachePkg::WORD_BITS] <= axiR_i.rdata;
    end
  end

  // per-set victim pointer, moves on every fill of that set
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rrPtr <= '0;
    end else if (state == cachePkg::RESPOND) begin
      rrPtr[reqIndex] <= nextPtr;
    end
  end

  always_comb begin
    fillEn_o = '0;
    if (state == cachePkg::RESPOND) begin
      fillEn_o[victim] = 1'b1;
    end
  end

  assign fillIndex_o = reqIndex;
  assign fillTag_o = reqAddr[cachePkg::OFFSET_BITS + INDEX_BITS +: TAG_BITS];
  assign fillLine_o = lineReg;

  // word goes out either from a hitting way or from the fresh line
  assign selLoad_o = (state == cachePkg::COMPARE && anyHit) || (state == cachePkg::RESPOND);
  assign refillSel_o = (state == cachePkg::RESPOND);
  assign wordOffset_o = reqAddr[cachePkg::OFFSET_BITS-1 -: 2];

  // beat address is line base plus 8 per beat
  assign axiAr_o.araddr = {reqAddr[$bits(cachePkg::addrT)-1:cachePkg::OFFSET_BITS], beat, 3'b000};
  // unprivileged, secure, instruction fetch
  assign axiAr_o.arprot = 3'b100;
  assign axiAr_o.arvalid = (state == cachePkg::REFILL_ADDR);
  assign rready_o = (state == cachePkg::REFILL_DATA);

  arAddrStable: assert property (
    @(posedge clk) disable iff (!rst_n)
    axiAr_o.arvalid && !arready_i |=> axiAr_o.arvalid && $stable(axiAr_o.araddr)
  );

  fillOneHot: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(fillEn_o)
  );

  // error responses are stored as data, just record that they occur
  errorBeat: cover property (
    @(posedge clk) disable iff (!rst_n)
    beatTaken && axiR_i.rresp != axiLitePkg::RESP_OKAY
  );

endmodule

//--- hdl/waySelect.sv
module waySelect #(
  parameter int NUM_WAYS = 2
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [NUM_WAYS-1:0]                  hit_i,
  input  cachePkg::lineT [NUM_WAYS-1:0]        wayLine_i,
  input  cachePkg::lineT                       refillLine_i,
  input  logic                                 refillSel_i,
  input  logic                                 selLoad_i,
  input  logic [1:0]                           wordOffset_i,
  output cachePkg::wordT                       rdData_o,
  output logic                                 dataOk_o
);

  cachePkg::lineT hitLine;
  cachePkg::lineT srcLine;

  // hit vector is one-hot, so an OR of masked lines is enough
  always_comb begin
    hitLine = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (hit_i[w]) begin
        hitLine = hitLine | wayLine_i[w];
      end
    end
  end

  assign srcLine = refillSel_i ? refillLine_i : hitLine;

  always_ff @(posedge clk) begin
    if (selLoad_i) begin
      rdData_o <= srcLine[wordOffset_i * cachePkg::WORD_BITS +: cachePkg::WORD_BITS];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dataOk_o <= 1'b0;
    end else begin
      dataOk_o <= selLoad_i;
    end
  end

  // a line lives in at most one way
  hitOneHot: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(hit_i)
  );

endmodule

//--- hdl/cacheWay.sv
module cacheWay #(
  parameter int NUM_SETS = 64,
  localparam int INDEX_BITS = $clog2(NUM_SETS),
  localparam int TAG_BITS = $bits(cachePkg::addrT) - INDEX_BITS - cachePkg::OFFSET_BITS
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  lookupEn_i,
  input  cachePkg::addrT        lookupAddr_i,
  input  logic                  fillEn_i,
  input  logic [INDEX_BITS-1:0] fillIndex_i,
  input  logic [TAG_BITS-1:0]   fillTag_i,
  input  cachePkg::lineT        fillLine_i,
  output logic                  hit_o,
  output cachePkg::lineT        line_o
);

  logic [NUM_SETS-1:0] validArr;
  logic [TAG_BITS-1:0] tagArr [NUM_SETS];
  cachePkg::lineT      lineArr [NUM_SETS];

  logic [INDEX_BITS-1:0] lookupIndex;
  logic [TAG_BITS-1:0]   lookupTag;

  // set contents captured at lookup
  logic                validQ;
  logic [TAG_BITS-1:0] tagQ;
  logic [TAG_BITS-1:0] reqTagQ;
  cachePkg::lineT      lineQ;

  assign lookupIndex = lookupAddr_i[cachePkg::OFFSET_BITS +: INDEX_BITS];
  assign lookupTag = lookupAddr_i[cachePkg::OFFSET_BITS + INDEX_BITS +: TAG_BITS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '0;
    end else if (fillEn_i) begin
      validArr[fillIndex_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagArr[fillIndex_i] <= fillTag_i;
      lineArr[fillIndex_i] <= fillLine_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= 1'b0;
    end else if (lookupEn_i) begin
      validQ <= validArr[lookupIndex];
    end
  end

  always_ff @(posedge clk) begin
    if (lookupEn_i) begin
      tagQ <= tagArr[lookupIndex];
      reqTagQ <= lookupTag;
      lineQ <= lineArr[lookupIndex];
    end
  end

  // compare against the tag of the latched request
  assign hit_o = validQ && (tagQ == reqTagQ);
  assign line_o = lineQ;

endmodule

//--- hdl/axiLitePkg.sv
package axiLitePkg;

  typedef logic [31:0] axiAddrT;
  typedef logic [63:0] axiDataT;
  typedef logic [7:0]  axiStrbT;
  typedef logic [2:0]  axiProtT;
  typedef logic [1:0]  axiRespT;

  // response codes
  localparam axiRespT RESP_OKAY   = 2'b00;
  localparam axiRespT RESP_EXOKAY = 2'b01;
  localparam axiRespT RESP_SLVERR = 2'b10;
  localparam axiRespT RESP_DECERR = 2'b11;

  // read address channel, master to slave
  typedef struct packed {
    axiAddrT araddr;
    axiProtT arprot;
    logic    arvalid;
  } axiArT;

  // read data channel, slave to master
  typedef struct packed {
    axiDataT rdata;
    axiRespT rresp;
    logic    rvalid;
  } axiRT;

  // write channels
  typedef struct packed {
    axiAddrT awaddr;
    axiProtT awprot;
    logic    awvalid;
  } axiAwT;

  typedef struct packed {
    axiDataT wdata;
    axiStrbT wstrb;
    logic    wvalid;
  } axiWT;

  typedef struct packed {
    axiRespT bresp;
    logic    bvalid;
  } axiBT;

endpackage

//--- hdl/cachePkg.sv
package cachePkg;

  // fetch address and data widths
  typedef logic [31:0]  addrT;
  typedef logic [63:0]  wordT;
  typedef logic [255:0] lineT;

  localparam int WORD_BITS = $bits(wordT);
  localparam int LINE_BYTES = 32;
  localparam int WORDS_PER_LINE = LINE_BYTES / (WORD_BITS / 8);

  // byte offset inside one line
  localparam int OFFSET_BITS = $clog2(LINE_BYTES);

  // lookup and refill sequencing
  typedef enum logic [2:0] {
    IDLE,
    COMPARE,
    REFILL_ADDR,
    REFILL_DATA,
    RESPOND
  } ctrlStateT;

endpackage
